/* nova_sum_macros.svh */
`ifndef NOVA_SUM_MACROS_SVH
`define NOVA_SUM_MACROS_SVH

// ------------------------------------------------------------
// slice and residual parser states
// ------------------------------------------------------------
`define SKIP_RUN_DURATION	5'd3

`define INTRA16_AC_0		5'd1
`define INTRA16_AC			5'd2
`define LUMA_LEVEL_0		5'd3
`define LUMA_LEVEL			5'd4
`define CHROMA_AC_0			5'd5
`define CHROMA_AC_CB		5'd6
`define CHROMA_AC_CR		5'd7

// ------------------------------------------------------------
// intra prediction modes
// ------------------------------------------------------------
`define INTRA4X4_DC			4'd2
`define INTRA16X16_DC		2'd2
`define INTRA_CHROMA_DC		2'd0

// luma fractional positions, {yfrac, xfrac}
`define POS_I				4'b1001
`define POS_K				4'b1011

// ------------------------------------------------------------
// counters and limits
// ------------------------------------------------------------
`define ROW_IDLE			3'd4
`define BLK_LAST			5'd23
`define MB_ROWS_LAST		4'd8

// upper-neighbour line RAM
// luma at 0..43, cb from 44, cr from 66
`define RAM_BASE_CB			7'd44
`define RAM_BASE_CR			7'd66

`endif

/* nova_sum_pkg.sv */
`default_nettype none

package nova_sum_pkg;

	typedef logic [7:0] pixel_t;
	typedef logic signed [8:0] residual_t;

	// p0 is the leftmost column, in the low byte
	typedef struct packed {
		pixel_t p3;
		pixel_t p2;
		pixel_t p1;
		pixel_t p0;
	} pix_row_t;

	typedef struct packed {
		residual_t r3;
		residual_t r2;
		residual_t r1;
		residual_t r0;
	} res_row_t;

	// row0 is the top row, in the low bits
	typedef struct packed {
		pix_row_t row3;
		pix_row_t row2;
		pix_row_t row1;
		pix_row_t row0;
	} pred_blk_t;

	typedef struct packed {
		res_row_t row3;
		res_row_t row2;
		res_row_t row1;
		res_row_t row0;
	} res_blk_t;

	// ------------------------------------------------------------
	// predictor and residual control
	// ------------------------------------------------------------
	typedef struct packed {
		logic [3:0] mb_type;
		logic [3:0] intra4x4_mode;
		logic [1:0] intra16_mode;
		logic [1:0] chroma_mode;
		logic [2:0] calc_counter;
	} intra_ctl_t;

	typedef struct packed {
		logic [1:0] valid;
		logic [3:0] pos_fracl;
		logic [3:0] calc_counter;
	} inter_ctl_t;

	typedef struct packed {
		logic [4:0] slice_state;
		logic [4:0] residual_state;
		logic [4:0] total_coeff;
		logic       cbp_luma_zero;
		logic [1:0] cbp_chroma;
		logic       dc_zero;
		residual_t  dc_scaled;
	} res_ctl_t;

	typedef struct packed {
		logic [3:0] mb_h;
		logic [3:0] mb_v;
	} mb_pos_t;

	typedef struct packed {
		logic       wr;
		logic [6:0] addr;
		logic [31:0] din;
	} ram_wr_t;

	// ------------------------------------------------------------
	// block counter in double-z order
	// ------------------------------------------------------------
	typedef struct packed {
		logic is_chroma;
		logic quad_row;
		logic quad_col;
		logic sub_row;
		logic sub_col;
	} blk_luma_t;

	typedef struct packed {
		logic is_chroma;
		logic spare;
		logic is_cr;
		logic sub_row;
		logic sub_col;
	} blk_chroma_t;

	typedef union packed {
		blk_luma_t   luma;
		blk_chroma_t chroma;
	} blk_idx_u;

endpackage

`default_nettype wire

/* blk_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "nova_sum_macros.svh"

module blk_sequencer import nova_sum_pkg::*; (
	input  wire logic       clk,
	input  wire logic       reset_n,
	input  wire logic       trigger,
	output logic [2:0]      row,
	output logic            end_of_blk,
	output blk_idx_u        blk_idx,
	output logic [4:0]      raster_idx
);

	logic [4:0] blk_cnt;

	// ------------------------------------------------------------
	// row counter, one row per cycle
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			row <= `ROW_IDLE;
		else if (trigger)
			row <= 3'd0;
		else if (row != `ROW_IDLE)
			row <= row + 3'd1;
	end

	assign end_of_blk = (row == 3'd3);

	// 24 blocks per macroblock, 16 luma then 4 cb and 4 cr
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			blk_cnt <= 5'd0;
		else if (end_of_blk)
			blk_cnt <= (blk_cnt == `BLK_LAST) ? 5'd0 : blk_cnt + 5'd1;
	end

	assign blk_idx = blk_cnt;

	// double-z to raster, only the top two quadrant pairs differ
	always_comb begin
		case (blk_cnt)
			5'd2:    raster_idx = 5'd4;
			5'd3:    raster_idx = 5'd5;
			5'd4:    raster_idx = 5'd2;
			5'd5:    raster_idx = 5'd3;
			5'd10:   raster_idx = 5'd12;
			5'd11:   raster_idx = 5'd13;
			5'd12:   raster_idx = 5'd10;
			5'd13:   raster_idx = 5'd11;
			default: raster_idx = blk_cnt;
		endcase
	end

	a_row_range: assert property (@(posedge clk) disable iff (!reset_n)
		row <= `ROW_IDLE);

	a_blk_range: assert property (@(posedge clk) disable iff (!reset_n)
		blk_cnt <= `BLK_LAST);

endmodule

`default_nettype wire

/* pred_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "nova_sum_macros.svh"

module pred_buffer import nova_sum_pkg::*; (
	input  wire logic       clk,
	input  wire logic       reset_n,
	input  wire intra_ctl_t intra_ctl,
	input  wire pix_row_t   intra_pe,
	input  wire inter_ctl_t inter_ctl,
	input  wire pix_row_t   inter_pe,
	input  wire blk_idx_u   blk_idx,
	output pred_blk_t       pred
);

	// raster order inside the block, index = row * 4 + column
	pixel_t pix [16];

	// one pixel per PE, PE k feeds row k
	pixel_t src [4];

	logic       intra_dc4;
	logic       intra_dc16;
	logic       half_pos;
	logic       bcast;
	logic       col_we;
	logic [1:0] col;

	// ------------------------------------------------------------
	// DC cases: PE0 result goes to every pixel
	// ------------------------------------------------------------
	assign intra_dc4 =
		(intra_ctl.mb_type[3:2] == 2'b11 && !blk_idx.luma.is_chroma &&
			intra_ctl.intra4x4_mode == `INTRA4X4_DC) ||
		(intra_ctl.mb_type[3] && blk_idx.chroma.is_chroma &&
			intra_ctl.chroma_mode == `INTRA_CHROMA_DC);

	assign intra_dc16 = intra_ctl.mb_type[3:2] == 2'b10 && !blk_idx.luma.is_chroma &&
		intra_ctl.intra16_mode == `INTRA16X16_DC;

	// half-sample positions i and k take two cycles per column
	assign half_pos = (inter_ctl.pos_fracl == `POS_I) || (inter_ctl.pos_fracl == `POS_K);

	always_comb begin
		bcast  = 1'b0;
		col_we = 1'b0;
		col    = 2'd0;
		src[0] = intra_pe.p0;
		src[1] = intra_pe.p1;
		src[2] = intra_pe.p2;
		src[3] = intra_pe.p3;

		if (intra_ctl.calc_counter != 3'd0) begin
			if (intra_dc4) begin
				bcast = (intra_ctl.calc_counter == 3'd3);
			end else if (intra_dc16) begin
				// whole 16x16 shares one DC, computed once at block 0
				bcast = (blk_idx == 5'd0) && (intra_ctl.calc_counter == 3'd1);
			end else begin
				// counter 4 down to 1 gives column 0 to 3
				col_we = (intra_ctl.calc_counter <= 3'd4);
				col    = 2'(3'd4 - intra_ctl.calc_counter);
			end
		end else if (inter_ctl.valid == 2'b01) begin
			src[0] = inter_pe.p0;
			src[1] = inter_pe.p1;
			src[2] = inter_pe.p2;
			src[3] = inter_pe.p3;
			if (half_pos) begin
				// 7, 5, 3, 1
				col_we = inter_ctl.calc_counter[0] && (inter_ctl.calc_counter <= 4'd7);
				col    = 2'((4'd7 - inter_ctl.calc_counter) >> 1);
			end else begin
				col_we = (inter_ctl.calc_counter != 4'd0) && (inter_ctl.calc_counter <= 4'd4);
				col    = 2'(4'd4 - inter_ctl.calc_counter);
			end
		end
	end

	// ------------------------------------------------------------
	// pixel registers
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < 16; i++)
				pix[i] <= '0;
		end else if (bcast) begin
			for (int i = 0; i < 16; i++)
				pix[i] <= src[0];
		end else if (col_we) begin
			for (int r = 0; r < 4; r++)
				pix[r * 4 + int'(col)] <= src[r];
		end
	end

	assign pred = {pix[15], pix[14], pix[13], pix[12],
		pix[11], pix[10], pix[9], pix[8],
		pix[7], pix[6], pix[5], pix[4],
		pix[3], pix[2], pix[1], pix[0]};

	// no 2x2 chroma capture path here
	a_no_inter_chroma: assert property (@(posedge clk) disable iff (!reset_n)
		intra_ctl.calc_counter != 3'd0 |-> inter_ctl.valid != 2'b10);

endmodule

`default_nettype wire

/* recon_sum.sv */
`timescale 1ns/10ps
`default_nettype none

`include "nova_sum_macros.svh"

module recon_sum import nova_sum_pkg::*; (
	input  wire logic       clk,
	input  wire logic       reset_n,
	input  wire logic [2:0] row,
	input  wire res_ctl_t   res_ctl,
	input  wire res_blk_t   residual,
	input  wire pred_blk_t  pred,
	output pix_row_t        sum_row,
	output logic [23:0]     right_column
);

	logic       all_zero;
	logic       only_dc;
	logic       bypass;
	pix_row_t   pred_row;
	res_row_t   res_row;
	pixel_t     pb [4];
	residual_t  ra [4];
	logic [9:0] acc [4];
	pixel_t     sum_pix [4];

	// ------------------------------------------------------------
	// residual classification
	// ------------------------------------------------------------
	// all_zero wins over only_dc
	always_comb begin
		all_zero = 1'b0;
		only_dc  = 1'b0;
		if (res_ctl.slice_state == `SKIP_RUN_DURATION) begin
			all_zero = 1'b1;
		end else begin
			case (res_ctl.residual_state)
				`INTRA16_AC_0: begin
					all_zero = res_ctl.dc_zero;
					only_dc  = !res_ctl.dc_zero;
				end
				`INTRA16_AC, `CHROMA_AC_CB, `CHROMA_AC_CR: begin
					all_zero = (res_ctl.total_coeff == 5'd0) && res_ctl.dc_zero;
					only_dc  = (res_ctl.total_coeff == 5'd0) && !res_ctl.dc_zero;
				end
				`LUMA_LEVEL_0:
					all_zero = 1'b1;
				`LUMA_LEVEL:
					all_zero = (res_ctl.total_coeff == 5'd0) || res_ctl.cbp_luma_zero;
				`CHROMA_AC_0: begin
					// cbp_chroma 1 carries DC only
					all_zero = (res_ctl.cbp_chroma == 2'd0) || res_ctl.dc_zero;
					only_dc  = (res_ctl.cbp_chroma != 2'd0) && !res_ctl.dc_zero;
				end
				default: ;
			endcase
		end
	end

	// row operands
	always_comb begin
		case (row)
			3'd0: begin
				pred_row = pred.row0;
				res_row  = residual.row0;
			end
			3'd1: begin
				pred_row = pred.row1;
				res_row  = residual.row1;
			end
			3'd2: begin
				pred_row = pred.row2;
				res_row  = residual.row2;
			end
			3'd3: begin
				pred_row = pred.row3;
				res_row  = residual.row3;
			end
			default: begin
				pred_row = '0;
				res_row  = '0;
			end
		endcase
	end

	assign bypass = (row == `ROW_IDLE) || all_zero;

	// ------------------------------------------------------------
	// four clipping adders
	// ------------------------------------------------------------
	always_comb begin
		pb[0] = pred_row.p0;
		pb[1] = pred_row.p1;
		pb[2] = pred_row.p2;
		pb[3] = pred_row.p3;
		ra[0] = only_dc ? res_ctl.dc_scaled : res_row.r0;
		ra[1] = only_dc ? res_ctl.dc_scaled : res_row.r1;
		ra[2] = only_dc ? res_ctl.dc_scaled : res_row.r2;
		ra[3] = only_dc ? res_ctl.dc_scaled : res_row.r3;
		for (int c = 0; c < 4; c++) begin
			acc[c] = {2'b00, pb[c]} + {ra[c][8], ra[c]};
			if (bypass)
				sum_pix[c] = pb[c];
			else if (acc[c][9])
				sum_pix[c] = 8'd0;
			else if (acc[c][8])
				sum_pix[c] = 8'd255;
			else
				sum_pix[c] = acc[c][7:0];
		end
	end

	assign sum_row = {sum_pix[3], sum_pix[2], sum_pix[1], sum_pix[0]};

	// right column for the left neighbour, row 3 is taken directly
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			right_column <= '0;
		else begin
			case (row)
				3'd0:    right_column[7:0]   <= sum_row.p3;
				3'd1:    right_column[15:8]  <= sum_row.p3;
				3'd2:    right_column[23:16] <= sum_row.p3;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* mbaddrb_wr_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "nova_sum_macros.svh"

module mbaddrb_wr_ctrl import nova_sum_pkg::*; (
	input  wire logic [2:0] row,
	input  wire blk_idx_u   blk_idx,
	input  wire mb_pos_t    mb_pos,
	input  wire logic       lower_mb_skip,
	input  wire pix_row_t   sum_row,
	output ram_wr_t         ram_wr
);

	logic       is_bottom;
	logic [6:0] base;

	// luma 10, 11, 14, 15 and chroma 18, 19, 22, 23
	assign is_bottom = blk_idx.luma.is_chroma ?
		(blk_idx.chroma.sub_row && !blk_idx.chroma.spare) :
		(blk_idx.luma.quad_row && blk_idx.luma.sub_row);

	assign base = blk_idx.chroma.is_cr ? `RAM_BASE_CR : `RAM_BASE_CB;

	// ------------------------------------------------------------
	// write strobe, address and data
	// ------------------------------------------------------------
	always_comb begin
		ram_wr    = '0;
		ram_wr.wr = (row == 3'd3) && is_bottom &&
			(mb_pos.mb_v != `MB_ROWS_LAST) && !lower_mb_skip;
		if (ram_wr.wr) begin
			if (!blk_idx.luma.is_chroma)
				// four words per macroblock
				ram_wr.addr = {1'b0, mb_pos.mb_h, 2'b00} +
					{5'd0, blk_idx.luma.quad_col, blk_idx.luma.sub_col};
			else
				// two words per macroblock per plane
				ram_wr.addr = base + {2'b00, mb_pos.mb_h, 1'b0} +
					{6'd0, blk_idx.chroma.sub_col};
			ram_wr.din = sum_row;
		end
		// chroma block indices stop at 23
		a_blk_in_range: assert (!blk_idx.chroma.is_chroma || !blk_idx.chroma.spare);
	end

endmodule

`default_nettype wire

/* sum_top.sv */
`timescale 1ns/10ps
`default_nettype none

module sum_top import nova_sum_pkg::*; (
	input  wire logic       clk,
	input  wire logic       reset_n,
	input  wire logic       trigger,
	input  wire intra_ctl_t intra_ctl,
	input  wire pix_row_t   intra_pe,
	input  wire inter_ctl_t inter_ctl,
	input  wire pix_row_t   inter_pe,
	input  wire res_ctl_t   res_ctl,
	input  wire res_blk_t   residual,
	input  wire mb_pos_t    mb_pos,
	input  wire logic       lower_mb_skip,
	output logic            end_of_blk,
	output logic [2:0]      row,
	output blk_idx_u        blk_idx,
	output logic [4:0]      raster_idx,
	output pix_row_t        sum_row,
	output logic [23:0]     right_column,
	output ram_wr_t         ram_wr
);

	pred_blk_t pred;

	// ------------------------------------------------------------
	// row and block sequencing
	// ------------------------------------------------------------
	blk_sequencer u_seq (
		.clk        (clk),
		.reset_n    (reset_n),
		.trigger    (trigger),
		.row        (row),
		.end_of_blk (end_of_blk),
		.blk_idx    (blk_idx),
		.raster_idx (raster_idx)
	);

	pred_buffer u_pred (
		.clk       (clk),
		.reset_n   (reset_n),
		.intra_ctl (intra_ctl),
		.intra_pe  (intra_pe),
		.inter_ctl (inter_ctl),
		.inter_pe  (inter_pe),
		.blk_idx   (blk_idx),
		.pred      (pred)
	);

	// prediction plus residual
	recon_sum u_sum (
		.clk          (clk),
		.reset_n      (reset_n),
		.row          (row),
		.res_ctl      (res_ctl),
		.residual     (residual),
		.pred         (pred),
		.sum_row      (sum_row),
		.right_column (right_column)
	);

	mbaddrb_wr_ctrl u_wr (
		.row           (row),
		.blk_idx       (blk_idx),
		.mb_pos        (mb_pos),
		.lower_mb_skip (lower_mb_skip),
		.sum_row       (sum_row),
		.ram_wr        (ram_wr)
	);

endmodule

`default_nettype wire

/* tb_sum.sv */
`timescale 1ns/10ps
`default_nettype none

`include "nova_sum_macros.svh"

module tb_sum import nova_sum_pkg::*; ();

	logic        clk;
	logic        reset_n;
	logic        trigger;
	intra_ctl_t  intra_ctl;
	pix_row_t    intra_pe;
	inter_ctl_t  inter_ctl;
	pix_row_t    inter_pe;
	res_ctl_t    res_ctl;
	res_blk_t    residual;
	mb_pos_t     mb_pos;
	logic        lower_mb_skip;
	logic        end_of_blk;
	logic [2:0]  row;
	blk_idx_u    blk_idx;
	logic [4:0]  raster_idx;
	pix_row_t    sum_row;
	logic [23:0] right_column;
	ram_wr_t     ram_wr;

	integer      seed;
	logic [31:0] rnd;

	// reference model state
	pred_blk_t   exp_pred;
	logic [2:0]  model_row;
	logic [4:0]  model_blk;
	logic [23:0] model_rc;
	pix_row_t    exp_sum;
	ram_wr_t     exp_ram;

	sum_top UUT (
		.clk           (clk),
		.reset_n       (reset_n),
		.trigger       (trigger),
		.intra_ctl     (intra_ctl),
		.intra_pe      (intra_pe),
		.inter_ctl     (inter_ctl),
		.inter_pe      (inter_pe),
		.res_ctl       (res_ctl),
		.residual      (residual),
		.mb_pos        (mb_pos),
		.lower_mb_skip (lower_mb_skip),
		.end_of_blk    (end_of_blk),
		.row           (row),
		.blk_idx       (blk_idx),
		.raster_idx    (raster_idx),
		.sum_row       (sum_row),
		.right_column  (right_column),
		.ram_wr        (ram_wr)
	);

	always #20 clk = ~clk;

	// ------------------------------------------------------------
	// reference functions
	// ------------------------------------------------------------
	// 0 full residual, 1 all zero, 2 DC only
	function automatic logic [1:0] classify(input res_ctl_t rc);
		logic no_coeff;
		no_coeff = (rc.total_coeff == 5'd0);
		if (rc.slice_state == `SKIP_RUN_DURATION)
			return 2'd1;
		case (rc.residual_state)
			`INTRA16_AC_0:
				return rc.dc_zero ? 2'd1 : 2'd2;
			`INTRA16_AC, `CHROMA_AC_CB, `CHROMA_AC_CR:
				if (no_coeff)
					return rc.dc_zero ? 2'd1 : 2'd2;
			`LUMA_LEVEL_0:
				return 2'd1;
			`LUMA_LEVEL:
				if (no_coeff || rc.cbp_luma_zero)
					return 2'd1;
			`CHROMA_AC_0:
				if (rc.cbp_chroma == 2'd0 || rc.dc_zero)
					return 2'd1;
				else
					return 2'd2;
			default: ;
		endcase
		return 2'd0;
	endfunction

	function automatic pix_row_t ref_sum(input pred_blk_t pb, input res_blk_t rb,
		input res_ctl_t rc, input logic [2:0] r);
		pix_row_t   s;
		logic [1:0] cls;
		int         ri;
		int         res;
		int         v;
		s = '0;
		ri = int'(r);
		// idle row gives zero
		if (ri > 3)
			return s;
		cls = classify(rc);
		for (int c = 0; c < 4; c++) begin
			if (cls == 2'd1)
				res = 0;
			else if (cls == 2'd2)
				res = int'($signed(rc.dc_scaled));
			else
				res = int'($signed(rb[36 * ri + 9 * c +: 9]));
			v = int'(pb[32 * ri + 8 * c +: 8]) + res;
			if (v < 0)
				v = 0;
			else if (v > 255)
				v = 255;
			s[8 * c +: 8] = 8'(v);
		end
		return s;
	endfunction

	// luma double-z bits are {quad_row, quad_col, sub_row, sub_col}
	// raster is {block row, block column} with row {quad_row, sub_row}
	function automatic logic [4:0] raster_of(input logic [4:0] b);
		if (b[4])
			return b;
		return {1'b0, b[3], b[1], b[2], b[0]};
	endfunction

	function automatic ram_wr_t ref_ram(input logic [2:0] r, input logic [4:0] blk,
		input mb_pos_t mp, input logic skip, input pix_row_t s);
		ram_wr_t w;
		int      b;
		int      a;
		logic    bottom;
		w = '0;
		b = int'(blk);
		bottom = (b == 10 || b == 11 || b == 14 || b == 15 ||
			b == 18 || b == 19 || b == 22 || b == 23);
		if (r == 3'd3 && bottom && mp.mb_v != 4'd8 && !skip) begin
			if (b < 16)
				a = 4 * int'(mp.mb_h) + (b < 14 ? b - 10 : b - 12);
			else
				a = (b >= 20 ? 66 : 44) + 2 * int'(mp.mb_h) + b % 2;
			w.wr = 1'b1;
			w.addr = 7'(a);
			w.din = s;
		end
		return w;
	endfunction

	assign exp_sum = ref_sum(exp_pred, residual, res_ctl, model_row);
	assign exp_ram = ref_ram(model_row, model_blk, mb_pos, lower_mb_skip, exp_sum);

	// row and block order, right column
	always @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			model_row <= 3'd4;
			model_blk <= 5'd0;
			model_rc <= '0;
		end else begin
			if (trigger)
				model_row <= 3'd0;
			else if (model_row != 3'd4)
				model_row <= model_row + 3'd1;
			if (model_row == 3'd3)
				model_blk <= (model_blk == 5'd23) ? 5'd0 : model_blk + 5'd1;
			case (model_row)
				3'd0:    model_rc[7:0] <= exp_sum.p3;
				3'd1:    model_rc[15:8] <= exp_sum.p3;
				3'd2:    model_rc[23:16] <= exp_sum.p3;
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_row(input string name, input pix_row_t got, input pix_row_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_column(input string name, input logic [23:0] got,
		input logic [23:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_ram(input string name, input ram_wr_t got, input ram_wr_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_seq(input string name, input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		check_seq("row", {2'd0, row}, {2'd0, model_row});
		check_seq("end_of_blk", {4'd0, end_of_blk}, {4'd0, model_row == 3'd3});
		check_seq("blk_idx", blk_idx, model_blk);
		check_seq("raster_idx", raster_idx, raster_of(model_blk));
		check_row("sum_row", sum_row, exp_sum);
		check_column("right_column", right_column, model_rc);
		check_ram("ram_wr", ram_wr, exp_ram);
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic set_column(input int c, input pix_row_t pe);
		for (int k = 0; k < 4; k++)
			exp_pred[32 * k + 8 * c +: 8] = pe[8 * k +: 8];
	endtask

	task automatic fill_block(input pixel_t p);
		for (int i = 0; i < 16; i++)
			exp_pred[8 * i +: 8] = p;
	endtask

	task automatic capture_intra(input logic dc);
		intra_ctl.mb_type = 4'b1100;
		intra_ctl.intra4x4_mode = dc ? `INTRA4X4_DC : 4'd0;
		intra_ctl.intra16_mode = 2'd0;
		intra_ctl.chroma_mode = 2'd1;
		inter_ctl = '0;
		for (int cnt = 4; cnt >= 1; cnt--) begin
			step();
			intra_ctl.calc_counter = 3'(cnt);
			intra_pe = $random(seed);
			if (dc && cnt == 3)
				fill_block(intra_pe.p0);
			else if (!dc)
				set_column(4 - cnt, intra_pe);
		end
		step();
		intra_ctl.calc_counter = 3'd0;
	endtask

	// half-sample positions write on odd counts only
	task automatic capture_inter(input logic half);
		int first;
		first = half ? 7 : 4;
		intra_ctl.calc_counter = 3'd0;
		inter_ctl.valid = 2'b01;
		inter_ctl.pos_fracl = half ? `POS_I : 4'd0;
		for (int cnt = first; cnt >= 1; cnt--) begin
			step();
			inter_ctl.calc_counter = 4'(cnt);
			inter_pe = $random(seed);
			if (!half)
				set_column(4 - cnt, inter_pe);
			else if (cnt % 2 == 1)
				set_column((7 - cnt) / 2, inter_pe);
		end
		step();
		inter_ctl = '0;
	endtask

	task automatic random_residual();
		for (int i = 0; i < 16; i++) begin
			rnd = $random(seed);
			residual[9 * i +: 9] = rnd[8:0];
		end
	endtask

	task automatic set_class(input logic [4:0] slice, input logic [4:0] state,
		input logic [4:0] total, input logic dc_zero);
		rnd = $random(seed);
		res_ctl.slice_state = slice;
		res_ctl.residual_state = state;
		res_ctl.total_coeff = total;
		res_ctl.cbp_luma_zero = 1'b0;
		res_ctl.cbp_chroma = 2'd2;
		res_ctl.dc_zero = dc_zero;
		res_ctl.dc_scaled = rnd[8:0];
	endtask

	task automatic run_block();
		int   n;
		logic seen;
		step();
		trigger = 1'b1;
		step();
		trigger = 1'b0;
		seen = 1'b0;
		n = 0;
		while (!seen && n < 8) begin
			@(negedge clk);
			seen = end_of_blk;
			n++;
		end
		if (!seen)
			stop_with_failure("timeout waiting for end_of_blk after trigger");
		step();
	endtask

	initial begin
		seed = 36;
		clk = 1'b0;
		reset_n = 1'b0;
		trigger = 1'b0;
		intra_ctl = '0;
		intra_pe = '0;
		inter_ctl = '0;
		inter_pe = '0;
		res_ctl = '0;
		residual = '0;
		mb_pos = '0;
		lower_mb_skip = 1'b0;
		exp_pred = '0;
		repeat (8) @(posedge clk);
		#2;
		reset_n = 1'b1;
		repeat (3) step();

		// normal intra capture, full residual
		set_class(5'd0, 5'd0, 5'd9, 1'b0);
		for (int i = 0; i < 2; i++) begin
			capture_intra(1'b0);
			random_residual();
			run_block();
		end

		// DC broadcast and inter capture, zero residual
		set_class(5'd0, `LUMA_LEVEL_0, 5'd3, 1'b0);
		capture_intra(1'b1);
		random_residual();
		run_block();
		capture_inter(1'b1);
		run_block();
		capture_inter(1'b0);
		run_block();

		// ------------------------------------------------------------
		// classification
		// ------------------------------------------------------------
		capture_intra(1'b0);
		random_residual();
		set_class(5'd0, `INTRA16_AC_0, 5'd5, 1'b0);
		run_block();
		set_class(5'd0, `LUMA_LEVEL, 5'd0, 1'b0);
		run_block();
		set_class(`SKIP_RUN_DURATION, 5'd0, 5'd4, 1'b0);
		run_block();
		set_class(5'd0, `CHROMA_AC_0, 5'd0, 1'b0);
		run_block();
		set_class(5'd0, `INTRA16_AC, 5'd0, 1'b1);
		run_block();
		set_class(5'd0, `INTRA16_AC, 5'd3, 1'b0);
		run_block();

		// full macroblock walk with line-RAM writes
		set_class(5'd0, 5'd0, 5'd7, 1'b0);
		for (int i = 0; i < 24; i++) begin
			rnd = $random(seed);
			mb_pos.mb_h = rnd[3:0];
			mb_pos.mb_v = (model_blk == 5'd15 || model_blk == 5'd22) ? 4'd8 : {1'b0, rnd[6:4]};
			lower_mb_skip = (model_blk == 5'd10 || model_blk == 5'd18);
			capture_inter(i % 2 == 1);
			random_residual();
			run_block();
		end

		repeat (2) step();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
nova_sum_pkg.sv
blk_sequencer.sv
pred_buffer.sv
recon_sum.sv
mbaddrb_wr_ctrl.sv
sum_top.sv
tb_sum.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_sum -o tb_sum \
	&& ./obj_dir/tb_sum > sim.log 2>&1 \
	|| echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -qF '*** PASSED ***' sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }
